// ==== src/mf_bus_pkg.sv ====
// --------------------------------------------------
// host port fields, mode in the upper address bits
// --------------------------------------------------
package mf_bus_pkg;

    localparam int BUS_DATA_W = 32;
    localparam int MODE_W     = 2;
    localparam int DIM_W      = 10;    // up to 1023 pixels per side

    typedef logic [BUS_DATA_W-1:0] bus_data_t;
    typedef logic [MODE_W-1:0]     bus_mode_t;
    typedef logic [DIM_W-1:0]      dim_t;

    // register map
    localparam bus_mode_t MODE_PIXEL  = 2'd0;
    localparam bus_mode_t MODE_CTRL   = 2'd1;
    localparam bus_mode_t MODE_WIDTH  = 2'd2;
    localparam bus_mode_t MODE_HEIGHT = 2'd3;

endpackage

// ==== src/mf_image_pkg.sv ====
// --------------------------------------------------
// 8-bit greyscale, 3x3 window, tap 0 top left
// --------------------------------------------------
package mf_image_pkg;

    localparam int PIX_W      = 8;
    localparam int WIN_TAPS   = 9;
    localparam int MEDIAN_TAP = 4;     // middle of nine sorted values
    localparam int TAP_W      = 4;
    localparam int COORD_W    = 10;

    typedef logic [PIX_W-1:0]          pixel_t;
    typedef logic [TAP_W-1:0]          tap_t;
    typedef logic [COORD_W-1:0]        coord_t;
    typedef logic [WIN_TAPS*PIX_W-1:0] window_t;   // slot i at bits i*PIX_W

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_SORT,
        S_WRITE,
        S_DONE
    } scan_state_t;

endpackage

// ==== src/mf_frame_ram.sv ====
// --------------------------------------------------
// read data one cycle after en_i, held otherwise
// --------------------------------------------------
module mf_frame_ram #(
    parameter int FRAME_ADDR_W = 18
) (
    input  logic                    CLK,
    input  logic                    en_i,
    input  logic                    we_i,
    input  logic [FRAME_ADDR_W-1:0] addr_i,
    input  mf_image_pkg::pixel_t    din_i,
    output mf_image_pkg::pixel_t    dout_o
);
    import mf_image_pkg::*;

    pixel_t mem [2**FRAME_ADDR_W];

    always_ff @(posedge CLK) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= din_i;
            end else begin
                dout_o <= mem[addr_i];
            end
        end
    end

endmodule

// ==== src/mf_reg_bank.sv ====
// --------------------------------------------------
// done is only reported while start is held high
// --------------------------------------------------
module mf_reg_bank (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  ena_i,
    input  logic                  wea_i,
    input  mf_bus_pkg::bus_mode_t mode_i,
    input  mf_bus_pkg::bus_data_t din_i,
    input  logic                  done_i,
    input  mf_image_pkg::pixel_t  out_pixel_i,
    output logic                  start_o,
    output mf_bus_pkg::dim_t      width_o,
    output mf_bus_pkg::dim_t      height_o,
    output mf_bus_pkg::bus_data_t dout_o
);
    import mf_bus_pkg::*;

    logic      start_q;
    dim_t      width_q;
    dim_t      height_q;
    bus_mode_t rd_mode_q;
    logic      rd_done_q;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            start_q   <= 1'b0;
            width_q   <= '0;
            height_q  <= '0;
            rd_mode_q <= MODE_PIXEL;
            rd_done_q <= 1'b0;
        end else if (ena_i) begin
            if (wea_i) begin
                case (mode_i)
                    MODE_CTRL:   start_q  <= din_i[0];
                    MODE_WIDTH:  width_q  <= din_i[DIM_W-1:0];
                    MODE_HEIGHT: height_q <= din_i[DIM_W-1:0];
                    default: ;   // pixel writes go straight to the ram
                endcase
            end else begin
                rd_mode_q <= mode_i;
                rd_done_q <= done_i & start_q;
            end
        end
    end

    // ram data arrives with the registered read mode
    always_comb begin
        case (rd_mode_q)
            MODE_CTRL:  dout_o = BUS_DATA_W'(rd_done_q);
            MODE_PIXEL: dout_o = rd_done_q ? BUS_DATA_W'(out_pixel_i) : '0;
            default:    dout_o = '0;
        endcase
    end

    assign start_o  = start_q;
    assign width_o  = width_q;
    assign height_o = height_q;

endmodule

// ==== src/mf_window_fetch.sv ====
// --------------------------------------------------
// padded taps still read the ram, data is dropped
// --------------------------------------------------
module mf_window_fetch #(
    parameter int FRAME_ADDR_W = 18
) (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    fetch_i,
    input  mf_image_pkg::tap_t      tap_i,
    input  mf_image_pkg::coord_t    row_i,
    input  mf_image_pkg::coord_t    col_i,
    input  logic [FRAME_ADDR_W-1:0] center_addr_i,
    input  mf_bus_pkg::dim_t        width_i,
    input  mf_bus_pkg::dim_t        height_i,
    input  mf_image_pkg::pixel_t    ram_data_i,
    output logic [FRAME_ADDR_W-1:0] ram_addr_o,
    output mf_image_pkg::window_t   window_o
);
    import mf_image_pkg::*;

    logic                    up;
    logic                    down;
    logic                    left;
    logic                    right;
    logic                    pad;
    logic [FRAME_ADDR_W-1:0] stride;
    logic [FRAME_ADDR_W-1:0] row_addr;
    logic                    vld_q;
    logic                    pad_q;
    tap_t                    tap_q;
    window_t                 win_q;

    // tap = 3*dy + dx, both 0..2
    assign up    = (tap_i < tap_t'(3));
    assign down  = (tap_i > tap_t'(5));
    assign left  = (tap_i == tap_t'(0)) || (tap_i == tap_t'(3)) || (tap_i == tap_t'(6));
    assign right = (tap_i == tap_t'(2)) || (tap_i == tap_t'(5)) || (tap_i == tap_t'(8));

    assign stride   = FRAME_ADDR_W'(width_i);
    assign row_addr = up   ? center_addr_i - stride :
                      down ? center_addr_i + stride : center_addr_i;
    assign ram_addr_o = left  ? row_addr - 1'b1 :
                        right ? row_addr + 1'b1 : row_addr;

    assign pad = (up    && (row_i == '0)) ||
                 (down  && (row_i == height_i - 1'b1)) ||
                 (left  && (col_i == '0)) ||
                 (right && (col_i == width_i - 1'b1));

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            vld_q <= 1'b0;
            pad_q <= 1'b0;
            tap_q <= '0;
            win_q <= '0;
        end else begin
            vld_q <= fetch_i;   // aligned with ram read latency
            pad_q <= pad;
            tap_q <= tap_i;
            if (vld_q) begin
                win_q[tap_q*PIX_W +: PIX_W] <= pad_q ? pixel_t'(0) : ram_data_i;
            end
        end
    end

    assign window_o = win_q;

endmodule

// ==== src/median_sorter.sv ====
// --------------------------------------------------
// valid_o 9 cycles after start_i, start ignored if busy
// --------------------------------------------------
module median_sorter (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  start_i,
    input  mf_image_pkg::window_t window_i,
    output logic                  valid_o,
    output mf_image_pkg::pixel_t  median_o
);
    import mf_image_pkg::*;

    logic       busy_q;
    logic       valid_q;
    logic [3:0] pass_q;
    window_t    data_q;

    // one odd-even transposition pass over neighbouring pairs
    function automatic window_t oet_pass(input window_t w, input logic odd);
        window_t r;
        pixel_t  a;
        pixel_t  b;
        r = w;
        for (int i = 0; i < WIN_TAPS - 1; i++) begin
            if ((i % 2) == odd) begin
                a = r[i*PIX_W +: PIX_W];
                b = r[(i+1)*PIX_W +: PIX_W];
                if (a > b) begin
                    r[i*PIX_W +: PIX_W]     = b;
                    r[(i+1)*PIX_W +: PIX_W] = a;
                end
            end
        end
        return r;
    endfunction

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            pass_q  <= '0;
            data_q  <= '0;
        end else begin
            valid_q <= 1'b0;
            if (!busy_q) begin
                if (start_i) begin
                    data_q <= oet_pass(window_i, 1'b0);   // pass 0 on load
                    pass_q <= 4'd1;
                    busy_q <= 1'b1;
                end
            end else begin
                data_q <= oet_pass(data_q, pass_q[0]);
                pass_q <= pass_q + 1'b1;
                if (pass_q == 4'(WIN_TAPS - 1)) begin
                    busy_q  <= 1'b0;
                    valid_q <= 1'b1;
                end
            end
        end
    end

    assign valid_o  = valid_q;
    assign median_o = data_q[MEDIAN_TAP*PIX_W +: PIX_W];   // held until next start

endmodule

// ==== src/mf_scan_ctrl.sv ====
// --------------------------------------------------
// 20 cycles per pixel, done held until start drops
// --------------------------------------------------
module mf_scan_ctrl #(
    parameter int FRAME_ADDR_W = 18
) (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    start_i,
    input  mf_bus_pkg::dim_t        width_i,
    input  mf_bus_pkg::dim_t        height_i,
    input  logic                    sort_valid_i,
    output logic                    busy_o,
    output logic                    done_o,
    output logic                    fetch_o,
    output mf_image_pkg::tap_t      tap_o,
    output mf_image_pkg::coord_t    row_o,
    output mf_image_pkg::coord_t    col_o,
    output logic [FRAME_ADDR_W-1:0] center_addr_o,
    output logic                    sort_start_o,
    output logic                    out_we_o
);
    import mf_image_pkg::*;

    scan_state_t             state_q;
    tap_t                    tap_q;
    coord_t                  row_q;
    coord_t                  col_q;
    logic [FRAME_ADDR_W-1:0] row_base_q;
    logic                    last_col;
    logic                    last_row;

    assign last_col = (col_q == width_i - 1'b1);
    assign last_row = (row_q == height_i - 1'b1);

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state_q    <= S_IDLE;
            tap_q      <= '0;
            row_q      <= '0;
            col_q      <= '0;
            row_base_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    tap_q      <= '0;
                    row_q      <= '0;
                    col_q      <= '0;
                    row_base_q <= '0;
                    if (start_i) begin
                        state_q <= S_FETCH;
                    end
                end
                S_FETCH: begin   // nine taps then one wait slot
                    if (tap_q == tap_t'(WIN_TAPS)) begin
                        tap_q   <= '0;
                        state_q <= S_SORT;
                    end else begin
                        tap_q <= tap_q + 1'b1;
                    end
                end
                S_SORT: begin
                    if (tap_q == tap_t'(WIN_TAPS - 1)) begin
                        tap_q   <= '0;
                        state_q <= S_WRITE;
                    end else begin
                        tap_q <= tap_q + 1'b1;
                    end
                end
                S_WRITE: begin
                    if (sort_valid_i) begin
                        if (last_col) begin
                            col_q      <= '0;
                            row_q      <= row_q + 1'b1;
                            row_base_q <= row_base_q + FRAME_ADDR_W'(width_i);
                            state_q    <= last_row ? S_DONE : S_FETCH;
                        end else begin
                            col_q   <= col_q + 1'b1;
                            state_q <= S_FETCH;
                        end
                    end
                end
                S_DONE: begin
                    if (!start_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign busy_o  = (state_q == S_FETCH) || (state_q == S_SORT) || (state_q == S_WRITE);
    assign done_o  = (state_q == S_DONE);
    assign fetch_o = (state_q == S_FETCH) && (tap_q < tap_t'(WIN_TAPS));
    assign tap_o   = tap_q;
    assign row_o   = row_q;
    assign col_o   = col_q;

    assign center_addr_o = row_base_q + FRAME_ADDR_W'(col_q);
    assign sort_start_o  = (state_q == S_SORT) && (tap_q == '0);
    assign out_we_o      = (state_q == S_WRITE) && sort_valid_i;

endmodule

// ==== src/median_filter_top.sv ====
// --------------------------------------------------
// host must not write pixels while a run is busy
// --------------------------------------------------
module median_filter_top #(
    parameter int FRAME_ADDR_W = 18
) (
    input  logic                                       CLK,
    input  logic                                       RST,
    input  logic                                       ena_i,
    input  logic                                       wea_i,
    input  logic [mf_bus_pkg::MODE_W+FRAME_ADDR_W-1:0] addr_i,
    input  mf_bus_pkg::bus_data_t                      din_i,
    output mf_bus_pkg::bus_data_t                      dout_o
);
    import mf_bus_pkg::*;
    import mf_image_pkg::*;

    bus_mode_t               mode;
    logic [FRAME_ADDR_W-1:0] host_addr;
    logic                    host_pix;
    logic                    start;
    logic                    busy;
    logic                    done;
    dim_t                    width;
    dim_t                    height;
    logic                    fetch;
    tap_t                    tap;
    coord_t                  row;
    coord_t                  col;
    logic [FRAME_ADDR_W-1:0] center_addr;
    logic [FRAME_ADDR_W-1:0] fetch_addr;
    logic                    sort_start;
    logic                    sort_valid;
    logic                    out_we;
    window_t                 window;
    pixel_t                  median;
    pixel_t                  in_rdata;
    pixel_t                  out_rdata;

    assign mode      = addr_i[FRAME_ADDR_W +: MODE_W];
    assign host_addr = addr_i[FRAME_ADDR_W-1:0];
    assign host_pix  = ena_i && (mode == MODE_PIXEL);

    mf_reg_bank u_reg_bank (
        .CLK         (CLK),
        .RST         (RST),
        .ena_i       (ena_i),
        .wea_i       (wea_i),
        .mode_i      (mode),
        .din_i       (din_i),
        .done_i      (done),
        .out_pixel_i (out_rdata),
        .start_o     (start),
        .width_o     (width),
        .height_o    (height),
        .dout_o      (dout_o)
    );

    mf_scan_ctrl #(.FRAME_ADDR_W(FRAME_ADDR_W)) u_scan_ctrl (
        .CLK           (CLK),
        .RST           (RST),
        .start_i       (start),
        .width_i       (width),
        .height_i      (height),
        .sort_valid_i  (sort_valid),
        .busy_o        (busy),
        .done_o        (done),
        .fetch_o       (fetch),
        .tap_o         (tap),
        .row_o         (row),
        .col_o         (col),
        .center_addr_o (center_addr),
        .sort_start_o  (sort_start),
        .out_we_o      (out_we)
    );

    mf_window_fetch #(.FRAME_ADDR_W(FRAME_ADDR_W)) u_window_fetch (
        .CLK           (CLK),
        .RST           (RST),
        .fetch_i       (fetch),
        .tap_i         (tap),
        .row_i         (row),
        .col_i         (col),
        .center_addr_i (center_addr),
        .width_i       (width),
        .height_i      (height),
        .ram_data_i    (in_rdata),
        .ram_addr_o    (fetch_addr),
        .window_o      (window)
    );

    median_sorter u_sorter (
        .CLK      (CLK),
        .RST      (RST),
        .start_i  (sort_start),
        .window_i (window),
        .valid_o  (sort_valid),
        .median_o (median)
    );

    // input frame, host writes when idle, engine reads when busy
    mf_frame_ram #(.FRAME_ADDR_W(FRAME_ADDR_W)) u_in_ram (
        .CLK    (CLK),
        .en_i   (busy ? fetch : host_pix),
        .we_i   (!busy && host_pix && wea_i),
        .addr_i (busy ? fetch_addr : host_addr),
        .din_i  (din_i[PIX_W-1:0]),
        .dout_o (in_rdata)
    );

    // output frame
    mf_frame_ram #(.FRAME_ADDR_W(FRAME_ADDR_W)) u_out_ram (
        .CLK    (CLK),
        .en_i   (out_we || (!busy && host_pix && !wea_i)),
        .we_i   (out_we),
        .addr_i (busy ? center_addr : host_addr),
        .din_i  (median),
        .dout_o (out_rdata)
    );

endmodule

// ==== sim/mf_checker.sv ====
// --------------------------------------------------
// done predicted at 20 cycles per pixel after start
// --------------------------------------------------
module mf_checker #(
    parameter int FRAME_ADDR_W = 10
) (
    input logic                                       CLK,
    input logic                                       RST,
    input logic                                       ena_i,
    input logic                                       wea_i,
    input logic [mf_bus_pkg::MODE_W+FRAME_ADDR_W-1:0] addr_i,
    input mf_bus_pkg::bus_data_t                      din_i,
    input mf_bus_pkg::bus_data_t                      dout_i,
    input int                                         test_id_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import mf_bus_pkg::*;

    localparam int CYCLES_PER_PIX = 20;
    localparam int DONE_LAG       = 2;    // start capture plus status read

    logic [7:0] image [2**FRAME_ADDR_W];
    int         width;
    int         height;
    int         run_cnt;
    logic       started;
    logic       done_exp;
    bus_mode_t  mode;
    int         pa;
    int         total;
    int         read_seq;
    int         checked_seq;
    int         rd_test;
    bus_data_t  expect_q;
    int         err_cnt = 0;
    int         check_cnt = 0;

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset_reads";
            2:       return "random_image";
            3:       return "busy_reads";
            4:       return "start_clear";
            5:       return "full_white";
            default: return "unknown";
        endcase
    endfunction

    function automatic int pixel_at(input int r, input int c);
        if (r < 0 || c < 0 || r >= height || c >= width) begin
            return 0;    // zero padding
        end
        return image[r * width + c];
    endfunction

    // plain insertion sort of the padded 3x3 window
    function automatic int padded_median(input int addr);
        int v[9];
        int r;
        int c;
        int k;
        int t;
        int j;
        r = addr / width;
        c = addr % width;
        k = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                v[k] = pixel_at(r + dr, c + dc);
                k++;
            end
        end
        for (int i = 1; i < 9; i++) begin
            t = v[i];
            j = i - 1;
            while (j >= 0 && v[j] > t) begin
                v[j + 1] = v[j];
                j--;
            end
            v[j + 1] = t;
        end
        return v[4];
    endfunction

    always @(posedge CLK) begin
        if (!RST) begin
            width    = 0;
            height   = 0;
            run_cnt  = 0;
            started  = 1'b0;
            read_seq = 0;
        end else begin
            if (started) begin
                run_cnt++;
            end
            total    = width * height * CYCLES_PER_PIX + DONE_LAG;
            done_exp = started && (run_cnt >= total);
            if (ena_i) begin
                mode = addr_i[FRAME_ADDR_W +: MODE_W];
                pa   = int'(addr_i[FRAME_ADDR_W-1:0]);
                if (wea_i) begin
                    case (mode)
                        MODE_PIXEL: begin
                            if (!started || done_exp) begin
                                image[pa] = din_i[7:0];
                            end
                        end
                        MODE_CTRL: begin
                            if (din_i[0] && !started) begin
                                run_cnt = 0;
                            end
                            started = din_i[0];
                        end
                        MODE_WIDTH:  width = int'(din_i[DIM_W-1:0]);
                        default:     height = int'(din_i[DIM_W-1:0]);
                    endcase
                end else begin
                    case (mode)
                        MODE_CTRL:  expect_q = bus_data_t'(done_exp);
                        MODE_PIXEL: expect_q = done_exp ? bus_data_t'(padded_median(pa)) : '0;
                        default:    expect_q = '0;
                    endcase
                    rd_test = test_id_i;
                    read_seq++;
                end
            end
        end
    end

    // read data is stable from the edge after the read until the next read
    always @(negedge CLK) begin
        if (!RST) begin
            checked_seq = 0;
        end else if (checked_seq != read_seq) begin
            checked_seq = read_seq;
            check_cnt++;
            if (dout_i !== expect_q) begin
                err_cnt++;
                $display("[ERROR] %s: expected %0d, actual %0d",
                         test_name(rd_test), expect_q, dout_i);
            end
        end
    end

endmodule

// ==== sim/tb_median_filter.sv ====
// --------------------------------------------------
// frame address width 10, images up to 1024 pixels
// --------------------------------------------------
module tb_median_filter;
    timeunit 1ns;
    timeprecision 1ps;
    import mf_bus_pkg::*;

    localparam int FRAME_ADDR_W = 10;
    localparam int ADDR_W       = MODE_W + FRAME_ADDR_W;
    localparam int SEED         = 21581;
    localparam int POLL_LIMIT   = 2000;
    localparam time DRIVE_DLY   = 5ns;

    logic              CLK;
    logic              RST;
    logic              ena;
    logic              wea;
    logic [ADDR_W-1:0] addr;
    bus_data_t         din;
    bus_data_t         dout;
    int                test_id;
    int                timeouts;
    logic              aborted;

    median_filter_top #(.FRAME_ADDR_W(FRAME_ADDR_W)) UUT (
        .CLK    (CLK),
        .RST    (RST),
        .ena_i  (ena),
        .wea_i  (wea),
        .addr_i (addr),
        .din_i  (din),
        .dout_o (dout)
    );

    mf_checker #(.FRAME_ADDR_W(FRAME_ADDR_W)) u_checker (
        .CLK       (CLK),
        .RST       (RST),
        .ena_i     (ena),
        .wea_i     (wea),
        .addr_i    (addr),
        .din_i     (din),
        .dout_i    (dout),
        .test_id_i (test_id)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // one transfer, taken at the second edge
    task automatic bus_cycle(input logic we, input bus_mode_t mode, input int pa,
                             input bus_data_t data);
        @(posedge CLK);
        #DRIVE_DLY;
        ena  = 1'b1;
        wea  = we;
        addr = {mode, FRAME_ADDR_W'(pa)};
        din  = data;
        @(posedge CLK);
        #DRIVE_DLY;
        ena = 1'b0;
        wea = 1'b0;
    endtask

    task automatic bus_write(input bus_mode_t mode, input int pa, input bus_data_t data);
        bus_cycle(1'b1, mode, pa, data);
    endtask

    task automatic bus_read(input bus_mode_t mode, input int pa, output bus_data_t data);
        bus_cycle(1'b0, mode, pa, '0);
        data = dout;
    endtask

    task automatic run_image(input int w, input int h, input logic white);
        bus_data_t rdata;
        int        polls;
        test_id = white ? 5 : 2;
        for (int p = 0; p < w * h; p++) begin
            bus_write(MODE_PIXEL, p, white ? 32'd255 : bus_data_t'($urandom_range(255, 0)));
        end
        bus_write(MODE_WIDTH, 0, w);
        bus_write(MODE_HEIGHT, 0, h);
        bus_write(MODE_CTRL, 0, 1);
        test_id = 3;
        bus_read(MODE_PIXEL, 0, rdata);   // engine still running
        bus_read(MODE_CTRL, 0, rdata);
        polls = 0;
        while (rdata[0] !== 1'b1 && polls < POLL_LIMIT) begin
            bus_read(MODE_CTRL, 0, rdata);
            polls++;
        end
        if (rdata[0] !== 1'b1) begin
            timeouts++;
            aborted = 1'b1;
            $display("timeout: done never set for %0dx%0d image after %0d polls", w, h, polls);
        end else begin
            test_id = white ? 5 : 2;
            for (int p = 0; p < w * h; p++) begin
                bus_read(MODE_PIXEL, p, rdata);
            end
            test_id = 4;
            bus_write(MODE_CTRL, 0, 0);
            bus_read(MODE_CTRL, 0, rdata);
            bus_read(MODE_PIXEL, 0, rdata);
        end
    endtask

    initial begin
        int        w;
        int        h;
        bus_data_t rdata;
        void'($urandom(SEED));
        RST      = 1'b0;
        ena      = 1'b0;
        wea      = 1'b0;
        addr     = '0;
        din      = '0;
        test_id  = 1;
        timeouts = 0;
        aborted  = 1'b0;
        repeat (4) @(posedge CLK);
        #DRIVE_DLY;
        RST = 1'b1;

        bus_read(MODE_CTRL, 0, rdata);
        bus_read(MODE_PIXEL, 0, rdata);
        bus_read(MODE_PIXEL, 7, rdata);

        for (int n = 0; n < 4; n++) begin
            w = $urandom_range(12, 3);
            h = $urandom_range(10, 3);
            if (!aborted) begin
                run_image(w, h, 1'b0);
            end
        end
        if (!aborted) begin
            run_image(5, 4, 1'b1);   // corners 0, rest 255
        end

        repeat (2) @(posedge CLK);
        $display("checks %0d, mismatches %0d, timeouts %0d",
                 u_checker.check_cnt, u_checker.err_cnt, timeouts);
        if (u_checker.err_cnt == 0 && timeouts == 0 && u_checker.check_cnt > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== median_filter.f ====
src/mf_bus_pkg.sv
src/mf_image_pkg.sv
src/mf_frame_ram.sv
src/mf_reg_bank.sv
src/mf_window_fetch.sv
src/median_sorter.sv
src/mf_scan_ctrl.sv
src/median_filter_top.sv
sim/mf_checker.sv
sim/tb_median_filter.sv

// ==== Bender.yml ====
package:
  name: median_filter

sources:
  - src/mf_bus_pkg.sv
  - src/mf_image_pkg.sv
  - src/mf_frame_ram.sv
  - src/mf_reg_bank.sv
  - src/mf_window_fetch.sv
  - src/median_sorter.sv
  - src/mf_scan_ctrl.sv
  - src/median_filter_top.sv
  - target: simulation
    files:
      - sim/mf_checker.sv
      - sim/tb_median_filter.sv
